// ==== src/rv32i_mem_defs.svh ====
`ifndef RV32I_MEM_DEFS_SVH
`define RV32I_MEM_DEFS_SVH

// --------------------
// Bus geometry
// --------------------
`define RV_XLEN      32 // Address and data width.
`define RV_MAP_SIZE  4  // Regions in the map.

// --------------------
// Region ranges
// --------------------
// Each region is half open, from _B up to but not including _E.
`define RV_REGION_0_B 32'h0000_0000 // Instruction RAM.
`define RV_REGION_0_E 32'h0000_0400

`define RV_REGION_1_B 32'h0000_2000 // Data RAM.
`define RV_REGION_1_E 32'h0000_2400

`define RV_REGION_2_B 32'h0000_9000 // GPIO.
`define RV_REGION_2_E 32'h0000_9004

`define RV_REGION_3_B 32'h0000_B000 // Machine timer.
`define RV_REGION_3_E 32'h0000_B010

// --------------------
// Block sizes
// --------------------
`define RV_RAM_WORDS 256 // Words per RAM.
`define RV_GPIO_W    16  // GPIO pins.

`endif

// ==== src/rv32i_mem_pkg.sv ====
package rv32i_mem_pkg;

  // --------------------
  // Region select
  // --------------------
  // Bit position of each region in the one-hot select.
  typedef enum logic [1:0] {
    IMEM  = 2'd0,
    DMEM  = 2'd1,
    GPIO  = 2'd2,
    TIMER = 2'd3
  } region_e;

  // --------------------
  // Timer registers
  // --------------------
  // Word offset within the timer region, address bits 3:2.
  typedef enum logic [1:0] {
    MTIME_LO    = 2'd0,
    MTIME_HI    = 2'd1,
    MTIMECMP_LO = 2'd2,
    MTIMECMP_HI = 2'd3
  } timer_reg_e;

endpackage

// ==== src/rv32i_memory.sv ====
`timescale 1ns/1ps
`include "rv32i_mem_defs.svh"

module rv32i_memory (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    read_i,
  input  logic                    write_i,
  input  logic [`RV_XLEN-1:0]     addr_i,

  input  logic [`RV_XLEN-1:0]     imem_rdata_i,
  input  logic [`RV_XLEN-1:0]     dmem_rdata_i,
  input  logic [`RV_XLEN-1:0]     gpio_rdata_i,
  input  logic [`RV_XLEN-1:0]     timer_rdata_i,

  output logic [`RV_MAP_SIZE-1:0] region_o,
  output logic                    imem_we_o,
  output logic                    dmem_we_o,
  output logic                    gpio_we_o,
  output logic                    timer_we_o,
  output logic [`RV_XLEN-1:0]     rdata_o,
  output logic                    illegal_access_o
);

  logic strobe;
  logic unmapped;

  // --------------------
  // Address decode
  // --------------------
  assign region_o[rv32i_mem_pkg::IMEM] =
    (addr_i >= `RV_REGION_0_B) && (addr_i < `RV_REGION_0_E);
  assign region_o[rv32i_mem_pkg::DMEM] =
    (addr_i >= `RV_REGION_1_B) && (addr_i < `RV_REGION_1_E);
  assign region_o[rv32i_mem_pkg::GPIO] =
    (addr_i >= `RV_REGION_2_B) && (addr_i < `RV_REGION_2_E);
  assign region_o[rv32i_mem_pkg::TIMER] =
    (addr_i >= `RV_REGION_3_B) && (addr_i < `RV_REGION_3_E);

  // --------------------
  // Write steering
  // --------------------
  assign imem_we_o  = write_i & region_o[rv32i_mem_pkg::IMEM];
  assign dmem_we_o  = write_i & region_o[rv32i_mem_pkg::DMEM];
  assign gpio_we_o  = write_i & region_o[rv32i_mem_pkg::GPIO];
  assign timer_we_o = write_i & region_o[rv32i_mem_pkg::TIMER];

  // --------------------
  // Read return
  // --------------------
  // Select is one-hot, so the order here does not matter.
  always_comb begin
    if (region_o[rv32i_mem_pkg::IMEM]) begin
      rdata_o = imem_rdata_i;
    end else if (region_o[rv32i_mem_pkg::DMEM]) begin
      rdata_o = dmem_rdata_i;
    end else if (region_o[rv32i_mem_pkg::GPIO]) begin
      rdata_o = gpio_rdata_i;
    end else if (region_o[rv32i_mem_pkg::TIMER]) begin
      rdata_o = timer_rdata_i;
    end else begin
      rdata_o = '0; // Unmapped reads return zero.
    end
  end

  // --------------------
  // Illegal access flag
  // --------------------
  assign strobe   = read_i | write_i;
  assign unmapped = (region_o == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      illegal_access_o <= 1'b0;
    end else if (strobe && unmapped) begin
      illegal_access_o <= 1'b1; // Sticky until reset.
    end
  end

endmodule

// ==== src/rv32i_ram.sv ====
`timescale 1ns/1ps
`include "rv32i_mem_defs.svh"

module rv32i_ram #(
  parameter int WORDS = `RV_RAM_WORDS
) (
  input  logic                     clk_i,
  input  logic                     we_i,
  input  logic [$clog2(WORDS)-1:0] addr_i,
  input  logic [`RV_XLEN-1:0]      wdata_i,
  output logic [`RV_XLEN-1:0]      rdata_o
);

  // --------------------
  // Storage
  // --------------------
  logic [`RV_XLEN-1:0] mem [WORDS];

  // Write lands on the edge that samples the strobe.
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // --------------------
  // Read port
  // --------------------
  assign rdata_o = mem[addr_i]; // Same-cycle read.

endmodule

// ==== src/rv32i_gpio.sv ====
`timescale 1ns/1ps
`include "rv32i_mem_defs.svh"

module rv32i_gpio (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   we_i,
  input  logic [`RV_XLEN-1:0]    wdata_i,
  input  logic [`RV_GPIO_W-1:0]  gpio_i,
  output logic [`RV_GPIO_W-1:0]  gpio_o,
  output logic [`RV_XLEN-1:0]    rdata_o
);

  logic [`RV_GPIO_W-1:0] sync_q1;
  logic [`RV_GPIO_W-1:0] sync_q2;

  // --------------------
  // Output port
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_o <= '0;
    end else if (we_i) begin
      gpio_o <= wdata_i[`RV_GPIO_W-1:0]; // Low bits only.
    end
  end

  // --------------------
  // Input synchronizer
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  // Pins read back two edges after they change.
  assign rdata_o = {{(`RV_XLEN - `RV_GPIO_W){1'b0}}, sync_q2};

endmodule

// ==== src/rv32i_timer.sv ====
`timescale 1ns/1ps
`include "rv32i_mem_defs.svh"

module rv32i_timer (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     we_i,
  input  rv32i_mem_pkg::timer_reg_e reg_sel_i,
  input  logic [`RV_XLEN-1:0]      wdata_i,
  output logic [`RV_XLEN-1:0]      rdata_o,
  output logic                     timer_irq_o
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;

  // --------------------
  // Counter and compare
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime       <= '0;
      mtimecmp    <= '1; // No interrupt until programmed.
      timer_irq_o <= 1'b0;
    end else begin
      mtime       <= mtime + 64'd1;
      timer_irq_o <= (mtime >= mtimecmp);
      if (we_i) begin
        case (reg_sel_i)
          rv32i_mem_pkg::MTIME_LO:    mtime <= {mtime[63:32], wdata_i}; // Load, no tick.
          rv32i_mem_pkg::MTIME_HI:    mtime <= {wdata_i, mtime[31:0]};
          rv32i_mem_pkg::MTIMECMP_LO: mtimecmp[31:0]  <= wdata_i;
          rv32i_mem_pkg::MTIMECMP_HI: mtimecmp[63:32] <= wdata_i;
        endcase
      end
    end
  end

  // --------------------
  // Register read
  // --------------------
  always_comb begin
    case (reg_sel_i)
      rv32i_mem_pkg::MTIME_LO:    rdata_o = mtime[31:0];
      rv32i_mem_pkg::MTIME_HI:    rdata_o = mtime[63:32];
      rv32i_mem_pkg::MTIMECMP_LO: rdata_o = mtimecmp[31:0];
      rv32i_mem_pkg::MTIMECMP_HI: rdata_o = mtimecmp[63:32];
      default:                    rdata_o = '0;
    endcase
  end

endmodule

// ==== src/rv32i_mem_system.sv ====
`timescale 1ns/1ps
`include "rv32i_mem_defs.svh"

module rv32i_mem_system (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  read_i,
  input  logic                  write_i,
  input  logic [`RV_XLEN-1:0]   addr_i,
  input  logic [`RV_XLEN-1:0]   wdata_i,
  input  logic [`RV_GPIO_W-1:0] gpio_i,
  output logic [`RV_XLEN-1:0]   rdata_o,
  output logic [`RV_GPIO_W-1:0] gpio_o,
  output logic                  timer_irq_o,
  output logic                  illegal_access_o
);

  logic                imem_we;
  logic                dmem_we;
  logic                gpio_we;
  logic                timer_we;
  logic [`RV_XLEN-1:0] imem_rdata;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic [`RV_XLEN-1:0] gpio_rdata;
  logic [`RV_XLEN-1:0] timer_rdata;

  // --------------------
  // Decoder
  // --------------------
  rv32i_memory rv32i_memory_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .read_i           (read_i),
    .write_i          (write_i),
    .addr_i           (addr_i),
    .imem_rdata_i     (imem_rdata),
    .dmem_rdata_i     (dmem_rdata),
    .gpio_rdata_i     (gpio_rdata),
    .timer_rdata_i    (timer_rdata),
    .region_o         (),
    .imem_we_o        (imem_we),
    .dmem_we_o        (dmem_we),
    .gpio_we_o        (gpio_we),
    .timer_we_o       (timer_we),
    .rdata_o          (rdata_o),
    .illegal_access_o (illegal_access_o)
  );

  // --------------------
  // Region blocks
  // --------------------
  rv32i_ram imem_inst (
    .clk_i   (clk_i),
    .we_i    (imem_we),
    .addr_i  (addr_i[9:2]), // Word index.
    .wdata_i (wdata_i),
    .rdata_o (imem_rdata)
  );

  rv32i_ram dmem_inst (
    .clk_i   (clk_i),
    .we_i    (dmem_we),
    .addr_i  (addr_i[9:2]),
    .wdata_i (wdata_i),
    .rdata_o (dmem_rdata)
  );

  rv32i_gpio gpio_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .we_i    (gpio_we),
    .wdata_i (wdata_i),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .rdata_o (gpio_rdata)
  );

  rv32i_timer timer_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .we_i        (timer_we),
    .reg_sel_i   (rv32i_mem_pkg::timer_reg_e'(addr_i[3:2])),
    .wdata_i     (wdata_i),
    .rdata_o     (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o; // 20 ns period.
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== verif/rv32i_mem_system_asserts.sv ====
`timescale 1ns/1ps
`include "rv32i_mem_defs.svh"

module rv32i_mem_system_asserts (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    read_i,
  input logic                    write_i,
  input logic [`RV_MAP_SIZE-1:0] region_i,
  input logic                    illegal_access_i
);

  // --------------------
  // Decoder properties
  // --------------------
  region_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(region_i))
    else $error("region select has more than one bit set");

  unmapped_sets_flag: assert property (@(posedge clk_i) disable iff (reset_i)
    ((read_i || write_i) && (region_i == '0)) |=> illegal_access_i)
    else $error("unmapped strobe did not set the illegal access flag");

  // Only a reset may clear the flag.
  flag_sticky: assert property (@(posedge clk_i)
    illegal_access_i |=> (illegal_access_i || $past(reset_i)))
    else $error("illegal access flag fell without a reset");

endmodule

bind rv32i_memory rv32i_mem_system_asserts rv32i_mem_system_asserts_inst (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .read_i           (read_i),
  .write_i          (write_i),
  .region_i         (region_o),
  .illegal_access_i (illegal_access_o)
);

// ==== verif/rv32i_mem_system_tb.sv ====
`timescale 1ns/1ps
`include "rv32i_mem_defs.svh"

module rv32i_mem_system_tb;

  localparam int MAX_ROWS = 64;
  localparam int OP_IDLE  = 0;
  localparam int OP_WR    = 1;
  localparam int OP_RD    = 2;
  localparam int OP_PIN   = 3; // Drive gpio_i, no strobe.

  logic                  clk;
  logic                  reset;
  logic                  rd_strobe;
  logic                  wr_strobe;
  logic [`RV_XLEN-1:0]   addr;
  logic [`RV_XLEN-1:0]   wdata;
  logic [`RV_GPIO_W-1:0] gpio_in;
  logic [`RV_XLEN-1:0]   rdata;
  logic [`RV_GPIO_W-1:0] gpio_out;
  logic                  timer_irq;
  logic                  illegal_access;

  // --------------------
  // Table and model state
  // --------------------
  int                    n_rows;
  int                    row_test    [MAX_ROWS];
  int                    row_op      [MAX_ROWS];
  logic [`RV_XLEN-1:0]   row_addr    [MAX_ROWS];
  logic [`RV_XLEN-1:0]   row_wdata   [MAX_ROWS];
  logic [`RV_XLEN-1:0]   row_rdata   [MAX_ROWS];
  logic                  row_illegal [MAX_ROWS];
  logic                  row_irq     [MAX_ROWS];
  logic [`RV_GPIO_W-1:0] row_gpio    [MAX_ROWS];

  logic [`RV_XLEN-1:0]   m_imem [`RV_RAM_WORDS];
  logic [`RV_XLEN-1:0]   m_dmem [`RV_RAM_WORDS];
  logic [63:0]           m_mtime;
  logic [63:0]           m_mtimecmp;
  logic                  m_irq;
  logic                  m_illegal;
  logic [`RV_GPIO_W-1:0] m_gpio_o;
  logic [`RV_GPIO_W-1:0] m_pins;
  logic [`RV_GPIO_W-1:0] m_sync1;
  logic [`RV_GPIO_W-1:0] m_sync2;

  logic [31:0]           lcg_state;
  int                    checks;
  int                    errors;
  int                    test_checks [5];
  int                    test_errors [5];
  int                    cycle_count = 0;
  int                    timeout_limit = 100;
  string                 test_name [5] = '{"ram write and read", "unmapped access", "gpio",
                                           "timer count and load", "timer interrupt"};

  tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .reset_o(reset));

  rv32i_mem_system rv32i_mem_system_inst (
    .clk_i            (clk),
    .reset_i          (reset),
    .read_i           (rd_strobe),
    .write_i          (wr_strobe),
    .addr_i           (addr),
    .wdata_i          (wdata),
    .gpio_i           (gpio_in),
    .rdata_o          (rdata),
    .gpio_o           (gpio_out),
    .timer_irq_o      (timer_irq),
    .illegal_access_o (illegal_access)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int region_of(input logic [`RV_XLEN-1:0] a);
    if (a >= `RV_REGION_0_B && a < `RV_REGION_0_E) return int'(rv32i_mem_pkg::IMEM);
    if (a >= `RV_REGION_1_B && a < `RV_REGION_1_E) return int'(rv32i_mem_pkg::DMEM);
    if (a >= `RV_REGION_2_B && a < `RV_REGION_2_E) return int'(rv32i_mem_pkg::GPIO);
    if (a >= `RV_REGION_3_B && a < `RV_REGION_3_E) return int'(rv32i_mem_pkg::TIMER);
    return -1; // Outside the map.
  endfunction

  function automatic logic [`RV_XLEN-1:0] model_read(input logic [`RV_XLEN-1:0] a);
    case (region_of(a))
      int'(rv32i_mem_pkg::IMEM): return m_imem[a[9:2]];
      int'(rv32i_mem_pkg::DMEM): return m_dmem[a[9:2]];
      int'(rv32i_mem_pkg::GPIO): return {{(`RV_XLEN-`RV_GPIO_W){1'b0}}, m_sync2};
      int'(rv32i_mem_pkg::TIMER): begin
        case (rv32i_mem_pkg::timer_reg_e'(a[3:2]))
          rv32i_mem_pkg::MTIME_LO:    return m_mtime[31:0];
          rv32i_mem_pkg::MTIME_HI:    return m_mtime[63:32];
          rv32i_mem_pkg::MTIMECMP_LO: return m_mtimecmp[31:0];
          default:                    return m_mtimecmp[63:32];
        endcase
      end
      default: return '0;
    endcase
  endfunction

  // Records what the row should see, then advances the model over the closing edge.
  task automatic add_row(input int test, input int op, input logic [`RV_XLEN-1:0] a,
                         input logic [`RV_XLEN-1:0] d);
    int          reg_idx;
    logic [63:0] mtime_next;
    reg_idx              = region_of(a);
    row_test[n_rows]    = test;
    row_op[n_rows]      = op;
    row_addr[n_rows]    = a;
    row_wdata[n_rows]   = d;
    row_rdata[n_rows]   = model_read(a);
    row_illegal[n_rows] = m_illegal;
    row_irq[n_rows]     = m_irq;
    row_gpio[n_rows]    = m_gpio_o;
    n_rows++;
    if ((op == OP_WR || op == OP_RD) && reg_idx < 0) m_illegal = 1'b1;
    m_irq      = (m_mtime >= m_mtimecmp); // Compare of the old values.
    mtime_next = m_mtime + 64'd1;
    if (op == OP_WR) begin
      case (reg_idx)
        int'(rv32i_mem_pkg::IMEM): m_imem[a[9:2]] = d;
        int'(rv32i_mem_pkg::DMEM): m_dmem[a[9:2]] = d;
        int'(rv32i_mem_pkg::GPIO): m_gpio_o = d[`RV_GPIO_W-1:0];
        int'(rv32i_mem_pkg::TIMER): begin
          case (rv32i_mem_pkg::timer_reg_e'(a[3:2]))
            rv32i_mem_pkg::MTIME_LO:    mtime_next = {m_mtime[63:32], d};
            rv32i_mem_pkg::MTIME_HI:    mtime_next = {d, m_mtime[31:0]};
            rv32i_mem_pkg::MTIMECMP_LO: m_mtimecmp[31:0] = d;
            default:                    m_mtimecmp[63:32] = d;
          endcase
        end
        default: ;
      endcase
    end
    m_mtime = mtime_next;
    if (op == OP_PIN) m_pins = d[`RV_GPIO_W-1:0];
    m_sync2 = m_sync1;
    m_sync1 = m_pins;
  endtask

  task automatic build_table();
    logic [`RV_XLEN-1:0] ram_addr [6];
    logic [63:0]         target;
    ram_addr = '{`RV_REGION_0_B, `RV_REGION_0_E - 4, `RV_REGION_0_B + 32'h200,
                 `RV_REGION_1_B, `RV_REGION_1_E - 4, `RV_REGION_1_B + 32'h200};
    foreach (ram_addr[i]) add_row(0, OP_WR, ram_addr[i], lcg_next());
    add_row(0, OP_WR, ram_addr[2], lcg_next()); // Overwrite, last one must win.
    foreach (ram_addr[i]) add_row(0, OP_RD, ram_addr[i], '0);
    add_row(1, OP_RD, 32'h0000_0400, '0);
    add_row(1, OP_IDLE, '0, '0);
    add_row(1, OP_RD, 32'h0000_1000, '0);
    add_row(1, OP_RD, 32'h0000_B010, '0);
    add_row(1, OP_RD, `RV_REGION_1_B, '0);
    add_row(2, OP_WR, `RV_REGION_2_B, lcg_next());
    add_row(2, OP_PIN, '0, lcg_next());
    repeat (3) add_row(2, OP_RD, `RV_REGION_2_B, '0);
    add_row(3, OP_WR, `RV_REGION_3_B, lcg_next());
    add_row(3, OP_WR, `RV_REGION_3_B + 32'h4, lcg_next());
    add_row(3, OP_RD, `RV_REGION_3_B + 32'h4, '0);
    repeat (4) add_row(3, OP_IDLE, '0, '0);
    add_row(3, OP_RD, `RV_REGION_3_B, '0);
    add_row(3, OP_WR, `RV_REGION_3_B + 32'h8, lcg_next());
    add_row(3, OP_WR, `RV_REGION_3_B + 32'hC, lcg_next());
    add_row(3, OP_RD, `RV_REGION_3_B + 32'h8, '0);
    add_row(3, OP_RD, `RV_REGION_3_B + 32'hC, '0);
    target = m_mtime + 64'd10;
    add_row(4, OP_WR, `RV_REGION_3_B + 32'hC, 32'hFFFF_FFFF); // Park compare high.
    add_row(4, OP_WR, `RV_REGION_3_B + 32'h8, target[31:0]);
    add_row(4, OP_WR, `RV_REGION_3_B + 32'hC, target[63:32]);
    repeat (14) add_row(4, OP_IDLE, '0, '0);
  endtask

  task automatic check_value(input string what, input int row, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    test_checks[row_test[row]]++;
    assert (got === exp) else begin
      $display("ERROR %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
      errors++;
      test_errors[row_test[row]]++;
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("Run stopped after %0d cycles without finishing the table.", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    rd_strobe  = 1'b0;
    wr_strobe  = 1'b0;
    addr       = '0;
    wdata      = '0;
    gpio_in    = '0;
    lcg_state  = 32'd80;
    n_rows     = 0;
    checks     = 0;
    errors     = 0;
    test_checks = '{default: 0};
    test_errors = '{default: 0};
    m_mtime    = 64'd1; // One edge passes between reset release and row 0.
    m_mtimecmp = '1;
    m_irq      = 1'b0;
    m_illegal  = 1'b0;
    m_gpio_o   = '0;
    m_pins     = '0;
    m_sync1    = '0;
    m_sync2    = '0;
    build_table();
    timeout_limit = n_rows * 4 + 100;
    wait (reset === 1'b0);
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk);
      rd_strobe <= (row_op[r] == OP_RD);
      wr_strobe <= (row_op[r] == OP_WR);
      addr      <= row_addr[r];
      wdata     <= row_wdata[r];
      if (row_op[r] == OP_PIN) gpio_in <= row_wdata[r][`RV_GPIO_W-1:0];
      @(negedge clk); // Mid-cycle, everything settled.
      if (row_op[r] == OP_RD) check_value("rdata", r, rdata, row_rdata[r]);
      check_value("illegal_access", r, 32'(illegal_access), 32'(row_illegal[r]));
      check_value("timer_irq", r, 32'(timer_irq), 32'(row_irq[r]));
      check_value("gpio_o", r, 32'(gpio_out), 32'(row_gpio[r]));
      if (r == n_rows - 1 || row_test[r + 1] != row_test[r]) begin
        $display("test %0d (%s): %0d checks, %0d errors", row_test[r],
                 test_name[row_test[r]], test_checks[row_test[r]], test_errors[row_test[r]]);
      end
    end
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== rv32i_mem_system.f ====
+incdir+src
src/rv32i_mem_pkg.sv
src/rv32i_memory.sv
src/rv32i_ram.sv
src/rv32i_gpio.sv
src/rv32i_timer.sv
src/rv32i_mem_system.sv
verif/tb_clock_gen.sv
verif/rv32i_mem_system_asserts.sv
verif/rv32i_mem_system_tb.sv

// ==== run.sh ====
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f rv32i_mem_system.f \
  --top-module rv32i_mem_system_tb \
  -o rv32i_mem_system_sim

./obj_dir/rv32i_mem_system_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log."
  exit 1
fi
